/* common/mdisp_defines.svh */
`ifndef MDISP_DEFINES_SVH
`define MDISP_DEFINES_SVH

// ==================================================
// Widths
// ==================================================
`define MDISP_DATA_W     32    // Stored word
`define MDISP_ADDR_W     9     // Storage address
`define MDISP_DIM_W      8     // Rows, cols, matrix count
`define MDISP_DIGITS     10    // Max decimal digits of a word

// ASCII codes used on the serial line
`define MDISP_ASC_SPACE  8'd32
`define MDISP_ASC_CR     8'd13
`define MDISP_ASC_LF     8'd10
`define MDISP_ASC_ZERO   8'd48

// 25 MHz / 115200 baud
`define MDISP_BAUD_DIV   217

`endif

/* common/mdisp_pkg.sv */
`default_nettype none

`include "mdisp_defines.svh"

package mdisp_pkg;

    // ==================================================
    // Shared types
    // ==================================================
    typedef logic [`MDISP_DATA_W-1:0] data_t;   // One storage word
    typedef logic [`MDISP_ADDR_W-1:0] addr_t;
    typedef logic [`MDISP_DIM_W-1:0]  dim_t;    // Dimension or matrix count
    typedef logic [7:0]               char_t;   // One ASCII byte

    // Print job type
    typedef enum logic {
        MODE_SINGLE = 1'b0,   // Matrix 0 only, no header
        MODE_LIST   = 1'b1    // Every matrix, numbered
    } disp_mode_e;

endpackage

`default_nettype wire

/* common/print_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Print requests from the sequencer to the printer
interface print_if;
    import mdisp_pkg::*;

    logic  num_req;   // Print value in decimal
    logic  chr_req;   // Print chr as is
    data_t value;
    char_t chr;
    logic  busy;      // Printer still working on a request

    modport seq (
        output num_req,
        output chr_req,
        output value,
        output chr,
        input  busy
    );

    modport prn (
        input  num_req,
        input  chr_req,
        input  value,
        input  chr,
        output busy
    );

endinterface

`default_nettype wire

/* design/uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

// 8N1 transmitter, LSB first, line idles high
module uart_tx #(
    parameter int BAUD_DIV = 217   // Clocks per bit
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              i_start,
    input  wire mdisp_pkg::char_t  i_data,
    output logic                   o_tx,
    output logic                   o_busy
);
    import mdisp_pkg::*;

    localparam int CNT_W = $clog2(BAUD_DIV + 1);

    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_cnt;    // 0 start, 1..8 data, 9 stop
    char_t            shreg;
    logic             bit_end;
    logic             launch;

    assign bit_end = (baud_cnt == CNT_W'(BAUD_DIV - 1));
    assign launch  = i_start && !o_busy;

    // ==================================================
    // Bit timing and line level
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_busy   <= 1'b0;
            o_tx     <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!o_busy) begin
            if (i_start) begin
                o_busy   <= 1'b1;
                o_tx     <= 1'b0;   // Start bit
                baud_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                o_busy <= 1'b0;     // Stop bit done
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
                o_tx    <= shreg[0];   // Ones behind the data give the stop bit
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // Data shifter
    always_ff @(posedge clk) begin
        if (launch)
            shreg <= i_data;
        else if (o_busy && bit_end)
            shreg <= {1'b1, shreg[7:1]};
    end

endmodule

`default_nettype wire

/* design/ascii_printer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mdisp_defines.svh"

module ascii_printer (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          i_tx_busy,
    output logic               o_tx_start,
    output mdisp_pkg::char_t   o_tx_data,
    print_if.prn               prn_bus
);
    import mdisp_pkg::*;

    localparam int PTR_W = $clog2(`MDISP_DIGITS);

    typedef enum logic [1:0] {
        P_IDLE,
        P_CONV,   // One digit per cycle
        P_SEND    // Digits out, MSD first
    } prn_state_e;

    prn_state_e       state;
    char_t            digit_buf [`MDISP_DIGITS];   // LSD at index 0
    logic [PTR_W-1:0] ptr;
    data_t            rem_val;     // Value still to convert
    logic             tx_start_q;
    char_t            tx_data_q;
    logic             tx_ready;
    logic             conv_last;
    char_t            conv_digit;

    // UART busy only rises the cycle after a start, so block back-to-back starts
    assign tx_ready   = !i_tx_busy && !tx_start_q;
    assign conv_last  = (rem_val < data_t'(10));
    assign conv_digit = char_t'(rem_val % data_t'(10)) + `MDISP_ASC_ZERO;

    assign prn_bus.busy = (state != P_IDLE);
    assign o_tx_start   = tx_start_q;
    assign o_tx_data    = tx_data_q;

    // ==================================================
    // Control
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= P_IDLE;
            ptr        <= '0;
            tx_start_q <= 1'b0;
        end else begin
            tx_start_q <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (prn_bus.num_req) begin
                        ptr   <= '0;
                        state <= P_CONV;
                    end else if (prn_bus.chr_req) begin
                        ptr   <= '0;   // Literal sits in slot 0
                        state <= P_SEND;
                    end
                end
                P_CONV: begin
                    if (conv_last) state <= P_SEND;   // ptr now on MSD
                    else           ptr   <= ptr + 1'b1;
                end
                P_SEND: if (tx_ready) begin
                    tx_start_q <= 1'b1;
                    if (ptr == '0) state <= P_IDLE;
                    else           ptr   <= ptr - 1'b1;
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    // ==================================================
    // Digit buffer and byte out
    // ==================================================
    always_ff @(posedge clk) begin
        case (state)
            P_IDLE: begin
                if (prn_bus.num_req)      rem_val      <= prn_bus.value;
                else if (prn_bus.chr_req) digit_buf[0] <= prn_bus.chr;
            end
            P_CONV: begin
                digit_buf[ptr] <= conv_digit;   // Remainder by ten
                rem_val        <= rem_val / data_t'(10);
            end
            P_SEND: if (tx_ready) tx_data_q <= digit_buf[ptr];
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/matrix_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mdisp_defines.svh"

module matrix_sequencer (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  i_en,
    input  var  mdisp_pkg::disp_mode_e i_mode,
    input  wire mdisp_pkg::dim_t       i_rows,
    input  wire mdisp_pkg::dim_t       i_cols,
    input  wire mdisp_pkg::dim_t       i_mat_cnt,
    input  wire mdisp_pkg::addr_t      i_base_addr,
    input  wire mdisp_pkg::data_t      i_storage_rdata,
    output mdisp_pkg::addr_t           o_req_addr,
    output logic                       o_done,
    print_if.seq                       prn_bus
);
    import mdisp_pkg::*;

    localparam int OFF_W = 3 * `MDISP_DIM_W;   // Wide enough for mat * rows * cols

    typedef enum logic [3:0] {
        S_IDLE,
        S_HDR_NUM,    // List header number
        S_HDR_CR,
        S_HDR_LF,
        S_ADDR,       // Register read address
        S_WAIT,       // Storage read latency
        S_CAPT,       // Sample read data
        S_VAL,
        S_SEP,        // Space, or CR at end of row
        S_EOL_LF,
        S_FLUSH,      // Last LF still with the printer
        S_DONE
    } seq_state_e;

    seq_state_e       state;
    dim_t             mat_idx;
    dim_t             row_idx;
    dim_t             col_idx;
    data_t            val_q;
    logic [OFF_W-1:0] elem_off;
    logic             last_col;
    logic             last_row;
    logic             last_mat;

    // ==================================================
    // Address and loop ends
    // ==================================================
    assign elem_off = OFF_W'(mat_idx) * OFF_W'(i_rows) * OFF_W'(i_cols)
                    + OFF_W'(row_idx) * OFF_W'(i_cols)
                    + OFF_W'(col_idx);

    // A zero dimension behaves like one
    assign last_col = (col_idx + 8'd1 >= i_cols);
    assign last_row = (row_idx + 8'd1 >= i_rows);
    assign last_mat = (i_mode == MODE_SINGLE) || (mat_idx + 8'd1 >= i_mat_cnt);

    // ==================================================
    // Requests to the printer
    // ==================================================
    // Pulses only while busy is low, busy is high in the state that follows
    assign prn_bus.num_req = !prn_bus.busy && (state == S_HDR_NUM || state == S_VAL);
    assign prn_bus.chr_req = !prn_bus.busy &&
                             (state == S_HDR_CR || state == S_HDR_LF ||
                              state == S_SEP    || state == S_EOL_LF);

    assign prn_bus.value = (state == S_HDR_NUM) ? data_t'(mat_idx) + data_t'(1) : val_q;

    always_comb begin
        case (state)
            S_HDR_CR: prn_bus.chr = `MDISP_ASC_CR;
            S_SEP:    prn_bus.chr = last_col ? `MDISP_ASC_CR : `MDISP_ASC_SPACE;
            default:  prn_bus.chr = `MDISP_ASC_LF;   // HDR_LF and EOL_LF
        endcase
    end

    assign o_done = (state == S_DONE);

    // ==================================================
    // Walk matrices, rows and columns
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            mat_idx    <= '0;
            row_idx    <= '0;
            col_idx    <= '0;
            o_req_addr <= '0;
        end else begin
            case (state)
                S_IDLE: if (i_en) begin
                    mat_idx <= '0;
                    row_idx <= '0;
                    col_idx <= '0;
                    state   <= (i_mode == MODE_LIST) ? S_HDR_NUM : S_ADDR;
                end
                S_HDR_NUM: if (!prn_bus.busy) state <= S_HDR_CR;
                S_HDR_CR:  if (!prn_bus.busy) state <= S_HDR_LF;
                S_HDR_LF:  if (!prn_bus.busy) state <= S_ADDR;
                S_ADDR: begin
                    o_req_addr <= i_base_addr + addr_t'(elem_off);
                    state      <= S_WAIT;
                end
                S_WAIT: state <= S_CAPT;
                S_CAPT: state <= S_VAL;
                S_VAL:  if (!prn_bus.busy) state <= S_SEP;
                S_SEP: if (!prn_bus.busy) begin
                    if (last_col) begin
                        state <= S_EOL_LF;
                    end else begin
                        col_idx <= col_idx + 8'd1;
                        state   <= S_ADDR;
                    end
                end
                S_EOL_LF: if (!prn_bus.busy) begin
                    col_idx <= '0;
                    if (!last_row) begin
                        row_idx <= row_idx + 8'd1;
                        state   <= S_ADDR;
                    end else if (last_mat) begin
                        state <= S_FLUSH;
                    end else begin
                        row_idx <= '0;
                        mat_idx <= mat_idx + 8'd1;
                        state   <= S_HDR_NUM;   // Only list mode gets here
                    end
                end
                S_FLUSH: if (!prn_bus.busy) state <= S_DONE;
                S_DONE:  if (!i_en) state <= S_IDLE;   // Hold done until en drops
                default: state <= S_IDLE;
            endcase
        end
    end

    // Captured storage word
    always_ff @(posedge clk) begin
        if (state == S_CAPT) val_q <= i_storage_rdata;
    end

endmodule

`default_nettype wire

/* design/matrix_display.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mdisp_defines.svh"

module matrix_display #(
    parameter int BAUD_DIV = `MDISP_BAUD_DIV
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  i_en,          // Start a print job
    input  var  mdisp_pkg::disp_mode_e i_mode,
    input  wire mdisp_pkg::dim_t       i_rows,
    input  wire mdisp_pkg::dim_t       i_cols,
    input  wire mdisp_pkg::dim_t       i_mat_cnt,
    input  wire mdisp_pkg::addr_t      i_base_addr,
    input  wire mdisp_pkg::data_t      i_storage_rdata,
    output mdisp_pkg::addr_t           o_req_addr,
    output logic                       o_uart_tx,
    output logic                       o_done
);
    import mdisp_pkg::*;

    logic  tx_start;
    char_t tx_data;
    logic  tx_busy;

    print_if prn_bus ();

    matrix_sequencer sequencer_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_en            (i_en),
        .i_mode          (i_mode),
        .i_rows          (i_rows),
        .i_cols          (i_cols),
        .i_mat_cnt       (i_mat_cnt),
        .i_base_addr     (i_base_addr),
        .i_storage_rdata (i_storage_rdata),
        .o_req_addr      (o_req_addr),
        .o_done          (o_done),
        .prn_bus         (prn_bus.seq)
    );

    ascii_printer printer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_tx_busy  (tx_busy),
        .o_tx_start (tx_start),
        .o_tx_data  (tx_data),
        .prn_bus    (prn_bus.prn)
    );

    uart_tx #(
        .BAUD_DIV (BAUD_DIV)
    ) uart_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_start (tx_start),
        .i_data  (tx_data),
        .o_tx    (o_uart_tx),
        .o_busy  (tx_busy)
    );

endmodule

`default_nettype wire

/* bench/storage_model.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mdisp_defines.svh"

// Word memory with one cycle read latency
module storage_model (
    input  wire logic             clk,
    input  wire mdisp_pkg::addr_t i_addr,
    output mdisp_pkg::data_t      o_rdata
);
    import mdisp_pkg::*;

    localparam int DEPTH = 1 << `MDISP_ADDR_W;

    data_t mem [DEPTH];   // Loaded from the testbench by hierarchical access

    // ==================================================
    // Registered read port
    // ==================================================
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_addr];
    end

endmodule

`default_nettype wire

/* bench/tb_matrix_display.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mdisp_defines.svh"

module tb_matrix_display;
    import mdisp_pkg::*;

    localparam int BAUD_DIV    = 8;
    localparam int MEM_DEPTH   = 1 << `MDISP_ADDR_W;
    localparam int RX_IDLE_MAX = 5000;    // Longest quiet gap on the line
    localparam int JOB_TIMEOUT = 50000;   // Cycles until done must rise
    localparam int BYTE_TIMEOUT = 2000;

    logic       clk;
    logic       rst_n;
    logic       en;
    disp_mode_e mode;
    dim_t       rows;
    dim_t       cols;
    dim_t       mat_cnt;
    addr_t      base_addr;
    data_t      storage_rdata;
    addr_t      req_addr;
    logic       uart_tx;
    logic       done;

    char_t rx_q [$];    // Bytes taken off the serial line
    char_t exp_q [$];   // Bytes still expected
    int    n_bytes;

    matrix_display #(
        .BAUD_DIV (BAUD_DIV)
    ) matrix_display_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_en            (en),
        .i_mode          (mode),
        .i_rows          (rows),
        .i_cols          (cols),
        .i_mat_cnt       (mat_cnt),
        .i_base_addr     (base_addr),
        .i_storage_rdata (storage_rdata),
        .o_req_addr      (req_addr),
        .o_uart_tx       (uart_tx),
        .o_done          (done)
    );

    storage_model storage_inst (
        .clk     (clk),
        .i_addr  (req_addr),
        .o_rdata (storage_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run;
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at the first failure");
    endtask

    // ==================================================
    // Reference model of the printed text
    // ==================================================
    function automatic void push_decimal(input data_t value);
        string txt;
        int    i;
        txt = $sformatf("%0d", value);   // Unsigned, no leading zeros
        for (i = 0; i < txt.len(); i++) begin
            exp_q.push_back(char_t'(txt[i]));
        end
    endfunction

    function automatic void build_expected(input disp_mode_e m_mode, input int n_rows,
                                           input int n_cols, input int n_mats,
                                           input int base);
        int m;
        int r;
        int c;
        int addr;
        int mats;
        mats = (m_mode == MODE_LIST) ? n_mats : 1;   // Single mode shows matrix 0 only
        for (m = 0; m < mats; m++) begin
            if (m_mode == MODE_LIST) begin
                push_decimal(data_t'(m + 1));   // 1-based header line
                exp_q.push_back(`MDISP_ASC_CR);
                exp_q.push_back(`MDISP_ASC_LF);
            end
            for (r = 0; r < n_rows; r++) begin
                for (c = 0; c < n_cols; c++) begin
                    addr = (base + m * n_rows * n_cols + r * n_cols + c) % MEM_DEPTH;
                    push_decimal(storage_inst.mem[addr]);
                    if (c == n_cols - 1) begin
                        exp_q.push_back(`MDISP_ASC_CR);
                        exp_q.push_back(`MDISP_ASC_LF);
                    end else begin
                        exp_q.push_back(`MDISP_ASC_SPACE);
                    end
                end
            end
        end
    endfunction

    // ==================================================
    // UART receiver and byte compare
    // ==================================================
    initial begin : uart_receiver
        int    idle;
        int    i;
        char_t b;
        idle = 0;
        forever begin
            @(negedge clk);
            if (!rst_n || uart_tx) begin
                idle++;
                assert (idle < RX_IDLE_MAX) else begin
                    $display("The UART line stayed idle too long, no start bit came");
                    abort_run();
                end
            end else begin
                idle = 0;
                repeat (BAUD_DIV / 2 - 1) @(negedge clk);   // Middle of start bit
                assert (!uart_tx) else begin
                    $display("A start bit on the UART line did not hold low");
                    abort_run();
                end
                for (i = 0; i < 8; i++) begin
                    repeat (BAUD_DIV) @(negedge clk);
                    b[i] = uart_tx;   // LSB first
                end
                repeat (BAUD_DIV) @(negedge clk);
                assert (uart_tx) else begin
                    $display("A UART frame ended without a stop bit");
                    abort_run();
                end
                rx_q.push_back(b);
            end
        end
    end

    initial begin : compare_bytes
        char_t got;
        char_t want;
        forever begin
            @(negedge clk);
            if (rx_q.size() > 0) begin
                got = rx_q.pop_front();
                assert (exp_q.size() > 0) else begin
                    $display("The UART sent an unexpected extra byte 0x%02h", got);
                    abort_run();
                end
                want = exp_q.pop_front();
                assert (got == want) else begin
                    $display("ERROR at %0t ns: byte %0d expected 0x%02h got 0x%02h",
                             $time, n_bytes, want, got);
                    abort_run();
                end
                n_bytes++;
            end
        end
    end

    // One print job from en high to done low
    task automatic run_job(input disp_mode_e j_mode, input int n_rows, input int n_cols,
                           input int n_mats, input int base);
        int cnt;
        build_expected(j_mode, n_rows, n_cols, n_mats, base);
        @(negedge clk);
        mode      = j_mode;
        rows      = dim_t'(n_rows);
        cols      = dim_t'(n_cols);
        mat_cnt   = dim_t'(n_mats);
        base_addr = addr_t'(base);
        en        = 1'b1;
        cnt = 0;
        while (!done) begin
            @(negedge clk);
            cnt++;
            assert (cnt < JOB_TIMEOUT) else begin
                $display("Timeout while waiting for o_done of a print job");
                abort_run();
            end
        end
        // Only the final LF may still be in flight
        assert (exp_q.size() == 1) else begin
            $display("ERROR at %0t ns: o_done rose with %0d bytes outstanding",
                     $time, exp_q.size());
            abort_run();
        end
        cnt = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            cnt++;
            assert (cnt < BYTE_TIMEOUT) else begin
                $display("Timeout while waiting for the last byte of a print job");
                abort_run();
            end
        end
        repeat (24) begin
            @(negedge clk);
            assert (done && uart_tx) else begin   // Done holds, line stays quiet
                $display("ERROR at %0t ns: done %0b tx %0b while en is held",
                         $time, done, uart_tx);
                abort_run();
            end
        end
        en = 1'b0;
        cnt = 0;
        while (done) begin
            @(negedge clk);
            cnt++;
            assert (cnt < 4) else begin
                $display("o_done stayed high after en was dropped");
                abort_run();
            end
        end
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin : stimulus
        int i;
        void'($urandom(32'h1e16ef6a));
        rst_n     = 1'b0;
        en        = 1'b0;
        mode      = MODE_SINGLE;
        rows      = '0;
        cols      = '0;
        mat_cnt   = '0;
        base_addr = '0;
        n_bytes   = 0;
        for (i = 0; i < MEM_DEPTH; i++) begin
            storage_inst.mem[i] = $urandom();
        end
        // Edge cases for the decimal converter
        storage_inst.mem[0]   = 32'd0;
        storage_inst.mem[1]   = 32'd7;
        storage_inst.mem[2]   = 32'hffff_ffff;
        storage_inst.mem[5]   = 32'd10;
        storage_inst.mem[103] = 32'd0;
        storage_inst.mem[107] = 32'd99;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        assert (uart_tx === 1'b1 && done === 1'b0) else begin
            $display("ERROR at %0t ns: after reset tx %b done %b", $time, uart_tx, done);
            abort_run();
        end

        run_job(MODE_SINGLE, 3, 4, 3, 0);   // Count is ignored in single mode
        run_job(MODE_LIST, 2, 3, 2, 100);
        run_job(MODE_SINGLE, 1, 5, 1, 400);

        @(negedge clk);
        if (n_bytes > 0 && exp_q.size() == 0 && rx_q.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("The run ended with no bytes checked or bytes left over");
            abort_run();
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/mdisp_pkg.sv
common/print_if.sv
design/uart_tx.sv
design/ascii_printer.sv
design/matrix_sequencer.sv
design/matrix_display.sv
bench/storage_model.sv
bench/tb_matrix_display.sv

/* Bender.yml */
package:
  name: matrix_display

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/mdisp_pkg.sv
      - common/print_if.sv
      - design/uart_tx.sv
      - design/ascii_printer.sv
      - design/matrix_sequencer.sv
      - design/matrix_display.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/storage_model.sv
      - bench/tb_matrix_display.sv
